// File: knightsTour.f
rtl/knightsPkg.sv
rtl/uartRx.sv
rtl/uartTx.sv
rtl/cmdAssembler.sv
rtl/cmdProc.sv
rtl/knightsTour.sv
dv/knightsTourTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the knightsTour testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary -sv --top-module knightsTourTb -f knightsTour.f \
  --Mdir obj_dir -o simv > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/simv > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
  exit 1
fi
exit 0

// File: dv/knightsTourTb.sv
`timescale 1ns/1ns
`default_nettype none

module knightsTourTb;

  import knightsPkg::*;

  // Short bit time keeps every UART frame at 160 clocks
  localparam int baudDiv = 16;
  localparam int waitLimit = 4000;

  logic clk;
  logic reset;
  logic RX;
  logic calDone;
  logic cntrIR;
  wire TX;
  wire strtCal;
  heading_t desiredHeading;
  wire moving;
  wire fanfare;

  logic [31:0] lfsrState;
  int errCnt = 0;
  bit timedOut = 1'b0;
  // Pulse and level counters taken on every rising clock edge
  int strtCalCnt = 0;
  int fanfareCnt = 0;
  int movingCnt = 0;
  // State of the TX line monitor
  bit monBusy = 1'b0;
  int monCnt = 0;
  byte_t monShift;
  byte_t rxQueue[$];

  knightsTour #(.baudDiv(baudDiv)) dut (
    .clk(clk), .reset(reset), .RX(RX), .calDone(calDone), .cntrIR(cntrIR),
    .TX(TX), .strtCal(strtCal), .desiredHeading(desiredHeading),
    .moving(moving), .fanfare(fanfare)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////

  // Counts strobes and moving cycles from the values held before each edge
  always @(posedge clk) begin
    if (!reset) begin
      if (strtCal) strtCalCnt++;
      if (fanfare) fanfareCnt++;
      if (moving) movingCnt++;
    end
  end

  // Decodes response bytes on TX and queues them in arrival order
  always @(posedge clk) begin
    if (reset) begin
      monBusy = 1'b0;
      monCnt = 0;
    end else if (!monBusy) begin
      if (TX === 1'b0) begin
        monBusy = 1'b1;
        monCnt = 0;
      end
    end else begin
      monCnt++;
      // Mid-bit points fall half a bit after each bit boundary
      if (monCnt > baudDiv && monCnt % baudDiv == baudDiv / 2) begin
        if (monCnt < 9 * baudDiv) begin
          monShift = {TX, monShift[7:1]};
        end else begin
          if (TX !== 1'b1) begin
            errCnt++;
            $display("A response byte on TX ended without a high stop bit");
          end
          rxQueue.push_back(monShift);
          monBusy = 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // The middle byte becomes the upper part of the heading, low nibble all ones
  function automatic heading_t expectHeading(input cmd_t c);
    return (heading_t'(c[11:4]) << 4) + heading_t'(4'hF);
  endfunction

  // Two center lines are crossed for every square
  function automatic int linesNeeded(input cmd_t c);
    return 2 * int'(c[3:0]);
  endfunction

  function automatic byte_t expectResponse(input logic [3:0] op);
    if (op == opCalibrate || op == opMove || op == opMoveFanfare) return respAck;
    return respNak;
  endfunction

  ////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////
  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      errCnt++;
      $display("[ERROR] %s: expected %0h, got %0h", name, expected, actual);
    end
  endtask

  task automatic reportTimeout(input string what);
    timedOut = 1'b1;
    $display("Timed out while waiting for %s", what);
  endtask

  // After a timeout the remaining waits fall through so the run reaches its end
  task automatic waitResponse(input string what, output byte_t value);
    int n;
    n = 0;
    value = '0;
    while (!timedOut && rxQueue.size() == 0 && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (rxQueue.size() != 0) value = rxQueue.pop_front();
    else if (!timedOut) reportTimeout(what);
  endtask

  task automatic waitMoving(input logic level, input string what);
    int n;
    n = 0;
    while (!timedOut && moving !== level && n < waitLimit) begin
      @(negedge clk);
      n++;
    end
    if (moving !== level && !timedOut) reportTimeout(what);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Each bit is held for one full bit time, LSB first, starting on a falling edge
  task automatic sendByte(input byte_t value);
    RX = 1'b0;
    repeat (baudDiv) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      RX = value[i];
      repeat (baudDiv) @(negedge clk);
    end
    RX = 1'b1;
    repeat (baudDiv) @(negedge clk);
  endtask

  task automatic sendCmd(input cmd_t c);
    sendByte(c[15:8]);
    sendByte(c[7:0]);
  endtask

  // Long enough for the two-flop synchronizer and the edge detector
  task automatic pulseLine();
    cntrIR = 1'b1;
    repeat (3) @(negedge clk);
    cntrIR = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  task automatic runCalibrate(input cmd_t c, input string name);
    int calStart;
    byte_t resp;
    calStart = strtCalCnt;
    sendCmd(c);
    // Calibration must hang until the gyro reports done
    repeat (4 * baudDiv) @(negedge clk);
    check({name, " strtCal pulses"}, 32'd1, 32'(strtCalCnt - calStart));
    check({name, " TX activity before calDone"}, 32'd0,
          32'(rxQueue.size() != 0 || monBusy));
    calDone = 1'b1;
    waitResponse({name, " response"}, resp);
    calDone = 1'b0;
    check({name, " response"}, 32'(expectResponse(c[15:12])), 32'(resp));
  endtask

  task automatic runMove(input cmd_t c, input string name);
    int lines;
    int ffStart;
    byte_t resp;
    lines = linesNeeded(c);
    ffStart = fanfareCnt;
    sendCmd(c);
    if (lines > 0) begin
      waitMoving(1'b1, {name, " to raise moving"});
      check({name, " heading"}, 32'(expectHeading(c)), 32'(desiredHeading));
      repeat (lines - 1) pulseLine();
      // One line short of the target nothing may have finished yet
      check({name, " moving before last line"}, 32'd1, 32'(moving));
      check({name, " TX activity before last line"}, 32'd0,
            32'(rxQueue.size() != 0 || monBusy));
      check({name, " fanfare before last line"}, 32'd0, 32'(fanfareCnt - ffStart));
      pulseLine();
    end
    waitMoving(1'b0, {name, " to drop moving"});
    waitResponse({name, " response"}, resp);
    check({name, " response"}, 32'(expectResponse(c[15:12])), 32'(resp));
    check({name, " final heading"}, 32'(expectHeading(c)), 32'(desiredHeading));
    check({name, " fanfare pulses"}, (c[15:12] == opMoveFanfare) ? 32'd1 : 32'd0,
          32'(fanfareCnt - ffStart));
  endtask

  task automatic runUnknown(input cmd_t c, input string name);
    int calStart;
    int movStart;
    byte_t resp;
    calStart = strtCalCnt;
    movStart = movingCnt;
    sendCmd(c);
    waitResponse({name, " response"}, resp);
    check({name, " response"}, 32'(expectResponse(c[15:12])), 32'(resp));
    check({name, " strtCal pulses"}, 32'd0, 32'(strtCalCnt - calStart));
    check({name, " moving cycles"}, 32'd0, 32'(movingCnt - movStart));
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [3:0] op;
    logic [1:0] sel;
    cmd_t c;
    lfsrState = 32'h76ae_faf2;
    RX = 1'b1;
    calDone = 1'b0;
    cntrIR = 1'b0;
    reset = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    check("reset TX", 32'd1, 32'(TX));
    check("reset strtCal", 32'd0, 32'(strtCal));
    check("reset moving", 32'd0, 32'(moving));
    check("reset fanfare", 32'd0, 32'(fanfare));
    check("reset heading", 32'd0, 32'(desiredHeading));

    runCalibrate(16'h2000, "calibrate");
    runMove(16'h4BF4, "move");
    runMove({opMoveFanfare, 8'(takeBits(8)), 4'h3}, "fanfare move");

    // Draw opcodes until one falls outside the valid set
    op = 4'(takeBits(4));
    while (op == opCalibrate || op == opMove || op == opMoveFanfare) op = 4'(takeBits(4));
    runUnknown({op, 12'(takeBits(12))}, "unknown opcode");

    for (int i = 0; i < 20; i++) begin
      sel = 2'(takeBits(2));
      while (sel == 2'd3) sel = 2'(takeBits(2));
      op = (sel == 2'd0) ? opCalibrate : (sel == 2'd1) ? opMove : opMoveFanfare;
      c = {op, 8'(takeBits(8)), 4'(takeBits(4))};
      if (op == opCalibrate) runCalibrate(c, $sformatf("random %0d calibrate", i));
      else runMove(c, $sformatf("random %0d move %04h", i, c));
    end

    $display("Finished with %0d errors and %0d timeouts", errCnt, int'(timedOut));
    if (errCnt == 0 && !timedOut) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/knightsTour.sv
`timescale 1ns/1ns
`default_nettype none

module knightsTour #(
  parameter int baudDiv = knightsPkg::baudDivDefault
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  RX,
  input  wire                  calDone,
  input  wire                  cntrIR,
  output wire                  TX,
  output wire                  strtCal,
  output knightsPkg::heading_t desiredHeading,
  output wire                  moving,
  output wire                  fanfare
);

  import knightsPkg::*;

  // Receiver to assembler
  byte_t rxData;
  logic rxRdy;
  // Assembler to command processor
  cmd_t cmd;
  logic cmdRdy;
  logic clrCmdRdy;
  // Command processor to transmitter
  byte_t txData;
  logic trmt;
  logic txBusy;

  ////////////////////////////////////////
  // Serial command path
  ////////////////////////////////////////
  uartRx #(.baudDiv(baudDiv)) uRx (
    .clk(clk), .reset(reset), .RX(RX), .rxData(rxData), .rxRdy(rxRdy)
  );

  cmdAssembler uAsm (
    .clk(clk), .reset(reset), .rxData(rxData), .rxRdy(rxRdy),
    .clrCmdRdy(clrCmdRdy), .cmd(cmd), .cmdRdy(cmdRdy)
  );

  // Decodes each command and drives the robot control levels
  cmdProc uProc (
    .clk(clk), .reset(reset), .cmd(cmd), .cmdRdy(cmdRdy), .calDone(calDone),
    .cntrIR(cntrIR), .txBusy(txBusy), .clrCmdRdy(clrCmdRdy), .strtCal(strtCal),
    .desiredHeading(desiredHeading), .moving(moving), .fanfare(fanfare),
    .trmt(trmt), .txData(txData)
  );

  // Response bytes go back out on the same baud rate
  uartTx #(.baudDiv(baudDiv)) uTx (
    .clk(clk), .reset(reset), .trmt(trmt), .txData(txData), .TX(TX),
    .txBusy(txBusy)
  );

endmodule

`default_nettype wire

// File: rtl/cmdProc.sv
`timescale 1ns/1ns
`default_nettype none

module cmdProc (
  input  wire                  clk,
  input  wire                  reset,
  input  knightsPkg::cmd_t     cmd,
  input  wire                  cmdRdy,
  input  wire                  calDone,
  input  wire                  cntrIR,
  input  wire                  txBusy,
  output logic                 clrCmdRdy,
  output logic                 strtCal,
  output knightsPkg::heading_t desiredHeading,
  output logic                 moving,
  output logic                 fanfare,
  output logic                 trmt,
  output knightsPkg::byte_t    txData
);

  import knightsPkg::*;

  typedef enum logic [1:0] {idle, calibrate, move, respond} state_t;

  state_t state;
  logic [3:0] opcode;
  logic irMeta;
  logic irSync;
  logic irPrev;
  logic irRise;
  squares_t squares;
  // Two lines are crossed per square, so up to 30 crossings
  logic [4:0] lineCnt;
  logic withFanfare;

  assign opcode = cmd[15:12];

  ////////////////////////////////////////
  // Center IR line crossings
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      irMeta <= 1'b0;
      irSync <= 1'b0;
      irPrev <= 1'b0;
    end else begin
      irMeta <= cntrIR;
      irSync <= irMeta;
      irPrev <= irSync;
    end
  end

  // One crossing per rising edge of the synchronized sensor
  assign irRise = irSync & ~irPrev;

  ////////////////////////////////////////
  // Command sequencer
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      clrCmdRdy <= 1'b0;
      strtCal <= 1'b0;
      desiredHeading <= '0;
      moving <= 1'b0;
      fanfare <= 1'b0;
      trmt <= 1'b0;
      txData <= '0;
      squares <= '0;
      lineCnt <= '0;
      withFanfare <= 1'b0;
    end else begin
      // Strobes last a single cycle unless set below
      clrCmdRdy <= 1'b0;
      strtCal <= 1'b0;
      fanfare <= 1'b0;
      trmt <= 1'b0;
      case (state)
        idle: begin
          if (cmdRdy) begin
            clrCmdRdy <= 1'b1;
            case (opcode)
              opCalibrate: begin
                strtCal <= 1'b1;
                state <= calibrate;
              end
              opMove, opMoveFanfare: begin
                // Middle byte of the command is the heading's upper byte
                desiredHeading <= {cmd[11:4], 4'hF};
                moving <= 1'b1;
                squares <= cmd[3:0];
                lineCnt <= '0;
                withFanfare <= (opcode == opMoveFanfare);
                state <= move;
              end
              default: begin
                // Anything else is refused straight away
                txData <= respNak;
                state <= respond;
              end
            endcase
          end
        end
        calibrate: begin
          // Gyro reports when its calibration is done
          if (calDone) begin
            txData <= respAck;
            state <= respond;
          end
        end
        move: begin
          // Zero squares matches on the first cycle and ends the move
          if (lineCnt == {squares, 1'b0}) begin
            moving <= 1'b0;
            fanfare <= withFanfare;
            txData <= respAck;
            state <= respond;
          end else if (irRise) begin
            lineCnt <= lineCnt + 5'd1;
          end
        end
        default: begin
          // Hold the response until the transmitter is free
          if (!txBusy) begin
            trmt <= 1'b1;
            state <= idle;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/cmdAssembler.sv
`timescale 1ns/1ns
`default_nettype none

module cmdAssembler (
  input  wire               clk,
  input  wire               reset,
  input  knightsPkg::byte_t rxData,
  input  wire               rxRdy,
  input  wire               clrCmdRdy,
  output knightsPkg::cmd_t  cmd,
  output logic              cmdRdy
);

  import knightsPkg::*;

  // High when the next byte to come is the low half
  logic waitLow;
  byte_t highByte;

  ////////////////////////////////////////
  // Byte order and the ready flag
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      waitLow <= 1'b0;
      cmdRdy <= 1'b0;
    end else begin
      // Bytes alternate high, low, high, low
      if (rxRdy) waitLow <= ~waitLow;
      // A fresh command wins over a clear in the same cycle
      if (rxRdy && waitLow) begin
        cmdRdy <= 1'b1;
      end else if (clrCmdRdy) begin
        cmdRdy <= 1'b0;
      end
    end
  end

  // The low byte completes the word, so a byte that shows up while
  // cmdRdy is still set always lands in the high half of the next one
  always_ff @(posedge clk) begin
    if (rxRdy && !waitLow) highByte <= rxData;
    if (rxRdy && waitLow) cmd <= {highByte, rxData};
  end

endmodule

`default_nettype wire

// File: rtl/uartTx.sv
`timescale 1ns/1ns
`default_nettype none

module uartTx #(
  parameter int baudDiv = knightsPkg::baudDivDefault
) (
  input  wire               clk,
  input  wire               reset,
  input  wire               trmt,
  input  knightsPkg::byte_t txData,
  output logic              TX,
  output logic              txBusy
);

  localparam int cntW = $clog2(baudDiv);

  logic [cntW-1:0] baudCnt;
  logic [3:0] bitCnt;
  // Stop bit, data and start bit, sent from bit 0 upward
  logic [9:0] frame;

  // Bit 0 of the frame is always the bit on the wire
  assign TX = frame[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      frame <= '1;
      txBusy <= 1'b0;
      baudCnt <= '0;
      bitCnt <= '0;
    end else if (!txBusy) begin
      // The start bit shows on TX from the edge after trmt
      if (trmt) begin
        frame <= {1'b1, txData, 1'b0};
        txBusy <= 1'b1;
        baudCnt <= '0;
        bitCnt <= '0;
      end
    end else if (baudCnt == cntW'(baudDiv - 1)) begin
      baudCnt <= '0;
      // After nine shifts the stop bit has had its full bit time
      if (bitCnt == 4'd9) begin
        txBusy <= 1'b0;
      end else begin
        // Ones fill in from the top so the line rests high when done
        frame <= {1'b1, frame[9:1]};
        bitCnt <= bitCnt + 1'b1;
      end
    end else begin
      baudCnt <= baudCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/uartRx.sv
`timescale 1ns/1ns
`default_nettype none

module uartRx #(
  parameter int baudDiv = knightsPkg::baudDivDefault
) (
  input  wire               clk,
  input  wire               reset,
  input  wire               RX,
  output knightsPkg::byte_t rxData,
  output logic              rxRdy
);

  localparam int cntW = $clog2(baudDiv);
  localparam int halfBit = baudDiv / 2;

  typedef enum logic [1:0] {idle, start, data, stop} state_t;

  state_t state;
  logic rxMeta;
  logic rxSync;
  logic rxPrev;
  logic [cntW-1:0] baudCnt;
  logic [2:0] bitCnt;
  logic bitEnd;

  // The line idles high, so the synchronizer comes out of reset at one
  always_ff @(posedge clk) begin
    if (reset) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end else begin
      rxMeta <= RX;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  // Marks the sampling point of a data or stop bit
  assign bitEnd = (baudCnt == cntW'(baudDiv - 1));

  // Pulse while the middle of the stop bit is being sampled
  assign rxRdy = (state == stop) && bitEnd;

  ////////////////////////////////////////
  // Bit sequencer
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
      baudCnt <= '0;
      bitCnt <= '0;
    end else begin
      baudCnt <= baudCnt + 1'b1;
      case (state)
        idle: begin
          // Falling edge on the line is the front of a start bit
          baudCnt <= '0;
          if (rxPrev && !rxSync) state <= start;
        end
        start: begin
          // Half a bit in we sit in the middle of the start bit
          if (baudCnt == cntW'(halfBit - 1)) begin
            baudCnt <= '0;
            bitCnt <= '0;
            // A line that is already high again was only a glitch
            state <= rxSync ? idle : data;
          end
        end
        data: begin
          if (bitEnd) begin
            baudCnt <= '0;
            bitCnt <= bitCnt + 1'b1;
            if (bitCnt == 3'd7) state <= stop;
          end
        end
        default: begin
          if (bitEnd) state <= idle;
        end
      endcase
    end
  end

  // LSB arrives first so bits enter at the top and move down
  always_ff @(posedge clk) begin
    if (state == data && bitEnd) rxData <= {rxSync, rxData[7:1]};
  end

endmodule

`default_nettype wire

// File: rtl/knightsPkg.sv
`default_nettype none

package knightsPkg;

  ////////////////////////////////////////
  // Widths that carry a meaning
  ////////////////////////////////////////

  // One byte as it travels on the serial link
  typedef logic [7:0] byte_t;
  // A full command, high byte received first
  typedef logic [15:0] cmd_t;
  // Heading handed to the steering loop
  typedef logic [11:0] heading_t;
  // Number of squares the knight moves in one command
  typedef logic [3:0] squares_t;

  // Clocks per bit for 19200 baud on a 50 MHz clock
  localparam int baudDivDefault = 2604;

  ////////////////////////////////////////
  // Command opcodes, the top nibble
  ////////////////////////////////////////
  localparam logic [3:0] opCalibrate = 4'h2;
  localparam logic [3:0] opMove = 4'h4;
  localparam logic [3:0] opMoveFanfare = 4'h5;

  // Response bytes sent back to the remote station
  localparam byte_t respAck = 8'hA5;
  localparam byte_t respNak = 8'h5A;

endpackage

`default_nettype wire
